/* rtl/rv_defines.svh */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// data and address width
`define RV_XLEN 32

// register address width
`define RV_REG_AW 5

// architectural register count
`define RV_NUM_REGS 32

// pc value out of reset
`define RV_RESET_PC 32'h8000_0000

// static next-pc increment, one word
`define RV_INST_STEP 32'd4

`endif

/* rtl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  // major opcodes the core executes
  // anything else retires as a no-op
  typedef enum logic [6:0] {
    OP_IMM    = 7'b001_0011,
    OP_LUI    = 7'b011_0111,
    OP_AUIPC  = 7'b001_0111,
    OP_JAL    = 7'b110_1111,
    OP_JALR   = 7'b110_0111,
    OP_SYSTEM = 7'b111_0011
  } opcode_e;

  // first adder operand
  // lui uses rs1 with x0 forced as the address
  typedef enum logic {
    SRC_A_RS1 = 1'b0,
    SRC_A_PC  = 1'b1
  } src_a_e;

  // register write data source
  typedef enum logic {
    WB_ALU  = 1'b0,
    WB_LINK = 1'b1
  } wb_sel_e;

  // next pc source
  typedef enum logic {
    PC_STATIC = 1'b0,
    PC_TARGET = 1'b1
  } pc_sel_e;

  // immediate format picked in decode
  typedef enum logic [1:0] {
    IMM_I = 2'b00,
    IMM_U = 2'b01,
    IMM_J = 2'b10
  } imm_kind_e;

endpackage

`default_nettype wire

/* rtl/rv_decode.sv */
`default_nettype none
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_decode (
  input  logic [`RV_XLEN-1:0]   inst,
  output logic [`RV_REG_AW-1:0] rs1_addr,
  output logic [`RV_REG_AW-1:0] rd,
  output logic [`RV_XLEN-1:0]   imm,
  output rv_pkg::src_a_e        src_a,
  output rv_pkg::pc_sel_e       pc_sel,
  output rv_pkg::wb_sel_e       wb_sel,
  output logic                  reg_we,
  output logic                  halt_req
);

  // inst[31:7] of ebreak is funct12 = 1 with all other fields zero
  localparam logic [24:0] EBREAK_FIELDS = {12'h001, 13'h0000};

  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [`RV_REG_AW-1:0] rs1_field;
  logic [`RV_XLEN-1:0]   imm_i;
  logic [`RV_XLEN-1:0]   imm_u;
  logic [`RV_XLEN-1:0]   imm_j;
  rv_pkg::imm_kind_e     imm_kind;

  // fixed field positions
  assign opcode    = inst[6:0];
  assign rd        = inst[11:7];
  assign funct3    = inst[14:12];
  assign rs1_field = inst[19:15];

  // I format is 12 bits sign extended
  assign imm_i = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};
  // U format keeps the upper 20 bits with the low 12 zero
  assign imm_u = {inst[31:12], 12'h000};
  // J format gathers 20 scrambled bits and is always even
  assign imm_j = {{(`RV_XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  // control decode
  always_comb begin
    // defaults are the no-op behaviour
    src_a    = rv_pkg::SRC_A_RS1;
    pc_sel   = rv_pkg::PC_STATIC;
    wb_sel   = rv_pkg::WB_ALU;
    imm_kind = rv_pkg::IMM_I;
    reg_we   = 1'b0;
    halt_req = 1'b0;
    rs1_addr = rs1_field;
    case (opcode)
      rv_pkg::OP_IMM: begin
        // only addi among the OP-IMM group
        reg_we = (funct3 == 3'b000);
      end
      rv_pkg::OP_LUI: begin
        // x0 as first operand makes the sum the immediate
        rs1_addr = '0;
        imm_kind = rv_pkg::IMM_U;
        reg_we   = 1'b1;
      end
      rv_pkg::OP_AUIPC: begin
        src_a    = rv_pkg::SRC_A_PC;
        imm_kind = rv_pkg::IMM_U;
        reg_we   = 1'b1;
      end
      rv_pkg::OP_JAL: begin
        src_a    = rv_pkg::SRC_A_PC;
        imm_kind = rv_pkg::IMM_J;
        pc_sel   = rv_pkg::PC_TARGET;
        wb_sel   = rv_pkg::WB_LINK;
        reg_we   = 1'b1;
      end
      rv_pkg::OP_JALR: begin
        // nonzero funct3 is treated as a no-op
        if (funct3 == 3'b000) begin
          pc_sel = rv_pkg::PC_TARGET;
          wb_sel = rv_pkg::WB_LINK;
          reg_we = 1'b1;
        end
      end
      rv_pkg::OP_SYSTEM: begin
        // only ebreak halts and other system encodings fall through
        halt_req = (inst[31:7] == EBREAK_FIELDS);
      end
      default: begin
        // loads, stores, branches and the rest retire silently
      end
    endcase
  end

  // immediate mux
  always_comb begin
    case (imm_kind)
      rv_pkg::IMM_U: imm = imm_u;
      rv_pkg::IMM_J: imm = imm_j;
      default:       imm = imm_i;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/rv_execute.sv */
`default_nettype none
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_execute (
  input  logic [`RV_XLEN-1:0] pc,
  input  logic [`RV_XLEN-1:0] rs1_data,
  input  logic [`RV_XLEN-1:0] imm,
  input  rv_pkg::src_a_e      src_a,
  input  rv_pkg::pc_sel_e     pc_sel,
  output logic [`RV_XLEN-1:0] alu_out,
  output logic [`RV_XLEN-1:0] pc_target
);

  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] sum;
  logic                is_jalr;

  // first operand, rs1 or pc
  // lui arrives here with rs1 = x0
  always_comb begin
    if (src_a == rv_pkg::SRC_A_PC) begin
      op_a = pc;
    end else begin
      op_a = rs1_data;
    end
  end

  // the one shared adder
  // second operand is always the immediate
  assign sum = op_a + imm;

  // write-back value for addi, lui, auipc
  assign alu_out = sum;

  // register-relative jump only
  assign is_jalr = (pc_sel == rv_pkg::PC_TARGET) && (src_a == rv_pkg::SRC_A_RS1);

  // jump target
  always_comb begin
    if (is_jalr) begin
      // jalr drops bit 0 of the computed address
      pc_target = {sum[`RV_XLEN-1:1], 1'b0};
    end else begin
      // jal target, pc plus even J immediate
      pc_target = sum;
    end
  end

endmodule

`default_nettype wire

/* rtl/rv_writeback.sv */
`default_nettype none
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_writeback (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [`RV_XLEN-1:0]   alu_out,
  input  logic [`RV_XLEN-1:0]   pc_target,
  input  logic [`RV_REG_AW-1:0] rd,
  input  logic                  reg_we,
  input  logic                  halt_req,
  input  rv_pkg::pc_sel_e       pc_sel,
  input  rv_pkg::wb_sel_e       wb_sel,
  output logic [`RV_XLEN-1:0]   pc,
  output logic                  rf_we,
  output logic [`RV_REG_AW-1:0] rf_waddr,
  output logic [`RV_XLEN-1:0]   rf_wdata,
  output logic                  wb_valid,
  output logic [`RV_REG_AW-1:0] wb_rd,
  output logic [`RV_XLEN-1:0]   wb_data,
  output logic                  halt
);

  logic [`RV_XLEN-1:0] pc_static;
  logic [`RV_XLEN-1:0] pc_next;

  // sequential address, also the link value
  assign pc_static = pc + `RV_INST_STEP;

  // halt has priority and holds the pc
  always_comb begin
    if (halt) begin
      pc_next = pc;
    end else if (pc_sel == rv_pkg::PC_TARGET) begin
      pc_next = pc_target;
    end else begin
      pc_next = pc_static;
    end
  end

  // pc register
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `RV_RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  // ebreak seen outside reset
  assign halt = halt_req && !reset;

  // write data, adder sum or return address
  assign rf_wdata = (wb_sel == rv_pkg::WB_LINK) ? pc_static : alu_out;
  assign rf_waddr = rd;
  // x0 writes dropped here, no commit for them either
  assign rf_we    = reg_we && (rd != '0) && !reset;

  // commit port mirrors the register write
  assign wb_valid = rf_we;
  assign wb_rd    = rd;
  assign wb_data  = rf_wdata;

  // jal and jalr targets from execute keep the pc even
  a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[0] == 1'b0)
    else $error("pc is not aligned, pc = %h", pc);

endmodule

`default_nettype wire

/* rtl/rv_regfile.sv */
`default_nettype none
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_regfile (
  input  logic                  clk,
  input  logic                  we,
  input  logic [`RV_REG_AW-1:0] waddr,
  input  logic [`RV_REG_AW-1:0] raddr,
  input  logic [`RV_XLEN-1:0]   wdata,
  output logic [`RV_XLEN-1:0]   rdata
);

  // storage, entry 0 exists but is never read
  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

  // one write port
  // new value visible the cycle after the write
  always_ff @(posedge clk) begin
    if (we) begin
      regs[waddr] <= wdata;
    end
  end

  // combinational read, x0 hardwired
  always_comb begin
    if (raddr == '0) begin
      rdata = '0;
    end else begin
      rdata = regs[raddr];
    end
  end

  // write-back filters rd 0 before it gets here
  a_no_x0_write: assert property (@(posedge clk) we |-> (waddr != '0))
    else $error("register file write to x0");

endmodule

`default_nettype wire

/* rtl/rv_core.sv */
`default_nettype none
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_core (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [`RV_XLEN-1:0]   inst,
  output logic [`RV_XLEN-1:0]   pc,
  output logic                  wb_valid,
  output logic [`RV_REG_AW-1:0] wb_rd,
  output logic [`RV_XLEN-1:0]   wb_data,
  output logic                  halt
);

  // decode outputs
  logic [`RV_REG_AW-1:0] rs1_addr;
  logic [`RV_REG_AW-1:0] rd;
  logic [`RV_XLEN-1:0]   imm;
  rv_pkg::src_a_e        src_a;
  rv_pkg::pc_sel_e       pc_sel;
  rv_pkg::wb_sel_e       wb_sel;
  logic                  reg_we;
  logic                  halt_req;

  // execute outputs
  logic [`RV_XLEN-1:0]   alu_out;
  logic [`RV_XLEN-1:0]   pc_target;

  // register file ports
  logic [`RV_XLEN-1:0]   rs1_data;
  logic                  rf_we;
  logic [`RV_REG_AW-1:0] rf_waddr;
  logic [`RV_XLEN-1:0]   rf_wdata;

  // fields, immediate and control
  rv_decode u_decode (
    .inst     (inst),
    .rs1_addr (rs1_addr),
    .rd       (rd),
    .imm      (imm),
    .src_a    (src_a),
    .pc_sel   (pc_sel),
    .wb_sel   (wb_sel),
    .reg_we   (reg_we),
    .halt_req (halt_req)
  );

  // adder and jump target
  rv_execute u_execute (
    .pc        (pc),
    .rs1_data  (rs1_data),
    .imm       (imm),
    .src_a     (src_a),
    .pc_sel    (pc_sel),
    .alu_out   (alu_out),
    .pc_target (pc_target)
  );

  // pc state, write data and commit port
  rv_writeback u_writeback (
    .clk       (clk),
    .reset     (reset),
    .alu_out   (alu_out),
    .pc_target (pc_target),
    .rd        (rd),
    .reg_we    (reg_we),
    .halt_req  (halt_req),
    .pc_sel    (pc_sel),
    .wb_sel    (wb_sel),
    .pc        (pc),
    .rf_we     (rf_we),
    .rf_waddr  (rf_waddr),
    .rf_wdata  (rf_wdata),
    .wb_valid  (wb_valid),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data),
    .halt      (halt)
  );

  // rs1 read only, nothing kept needs rs2
  rv_regfile u_regfile (
    .clk   (clk),
    .we    (rf_we),
    .waddr (rf_waddr),
    .raddr (rs1_addr),
    .wdata (rf_wdata),
    .rdata (rs1_data)
  );

endmodule

`default_nettype wire

/* test/tb_rv_core.sv */
`default_nettype none
`timescale 1ns/1ps
`include "rv_defines.svh"

module tb_rv_core;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_TESTS    = 23;

  // major opcodes from the ISA manual
  localparam logic [6:0] OPC_IMM   = 7'h13;
  localparam logic [6:0] OPC_LUI   = 7'h37;
  localparam logic [6:0] OPC_AUIPC = 7'h17;
  localparam logic [6:0] OPC_JALR  = 7'h67;
  localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

  logic                  clk;
  logic                  reset;
  logic [`RV_XLEN-1:0]   inst;
  logic [`RV_XLEN-1:0]   pc;
  logic                  wb_valid;
  logic [`RV_REG_AW-1:0] wb_rd;
  logic [`RV_XLEN-1:0]   wb_data;
  logic                  halt;

  // program table, one row per cycle
  string       tbl_name  [NUM_TESTS];
  logic [31:0] tbl_inst  [NUM_TESTS];
  logic [31:0] tbl_pc    [NUM_TESTS];
  logic        tbl_valid [NUM_TESTS];
  logic [4:0]  tbl_rd    [NUM_TESTS];
  logic [31:0] tbl_data  [NUM_TESTS];
  logic        tbl_halt  [NUM_TESTS];
  int          n_entries;
  int          errors;
  int          checks;

  rv_core u_rv_core (
    .clk      (clk),
    .reset    (reset),
    .inst     (inst),
    .pc       (pc),
    .wb_valid (wb_valid),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data),
    .halt     (halt)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // I format word, funct3 zero
  function automatic logic [31:0] i_format(input logic [6:0] opcode, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [11:0] imm);
    i_format = {imm, rs1, 3'b000, rd, opcode};
  endfunction

  function automatic logic [31:0] u_format(input logic [6:0] opcode, input logic [4:0] rd,
                                           input logic [19:0] imm);
    u_format = {imm, rd, opcode};
  endfunction

  // jal, byte offset in imm, bit 0 ignored
  function automatic logic [31:0] j_format(input logic [4:0] rd, input logic [20:0] imm);
    j_format = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  task automatic add_entry(input string name, input logic [31:0] word, input logic [31:0] exp_pc,
                           input logic exp_valid, input logic [4:0] exp_rd,
                           input logic [31:0] exp_data, input logic exp_halt);
    tbl_name[n_entries]  = name;
    tbl_inst[n_entries]  = word;
    tbl_pc[n_entries]    = exp_pc;
    tbl_valid[n_entries] = exp_valid;
    tbl_rd[n_entries]    = exp_rd;
    tbl_data[n_entries]  = exp_data;
    tbl_halt[n_entries]  = exp_halt;
    n_entries++;
  endtask

  task automatic compare_value(input string name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    assert (actual === expected)
      else begin
        errors++;
        $display("FAILED %s %s: expected %h, actual %h", name, field, expected, actual);
      end
  endtask

  task automatic build_table();
    // values built up from x0 and earlier results
    add_entry("addi_pos", i_format(OPC_IMM, 5'd1, 5'd0, 12'd5), 32'h8000_0000, 1, 5'd1, 32'd5, 0);
    add_entry("addi_neg", i_format(OPC_IMM, 5'd2, 5'd1, 12'hffd), 32'h8000_0004, 1, 5'd2, 32'd2, 0);
    add_entry("addi_max", i_format(OPC_IMM, 5'd3, 5'd2, 12'h7ff), 32'h8000_0008, 1, 5'd3,
              32'h0000_0801, 0);
    add_entry("addi_m1", i_format(OPC_IMM, 5'd4, 5'd0, 12'hfff), 32'h8000_000c, 1, 5'd4,
              32'hffff_ffff, 0);
    // write to x0 is dropped, x0 still reads zero next
    add_entry("addi_x0", i_format(OPC_IMM, 5'd0, 5'd1, 12'd7), 32'h8000_0010, 0, 5'd0, 32'd0, 0);
    add_entry("read_x0", i_format(OPC_IMM, 5'd5, 5'd0, 12'd9), 32'h8000_0014, 1, 5'd5, 32'd9, 0);
    add_entry("lui", u_format(OPC_LUI, 5'd6, 20'h12345), 32'h8000_0018, 1, 5'd6, 32'h1234_5000, 0);
    add_entry("lui_neg", u_format(OPC_LUI, 5'd7, 20'hfffff), 32'h8000_001c, 1, 5'd7,
              32'hffff_f000, 0);
    add_entry("auipc", u_format(OPC_AUIPC, 5'd8, 20'h00001), 32'h8000_0020, 1, 5'd8,
              32'h8000_1020, 0);
    // sum wraps past 2^32
    add_entry("auipc_wrap", u_format(OPC_AUIPC, 5'd9, 20'h80000), 32'h8000_0024, 1, 5'd9,
              32'h0000_0024, 0);
    // jal +16, link pc+4
    add_entry("jal_fwd", j_format(5'd1, 21'h10), 32'h8000_0028, 1, 5'd1, 32'h8000_002c, 0);
    add_entry("use_link", i_format(OPC_IMM, 5'd10, 5'd1, 12'd0), 32'h8000_0038, 1, 5'd10,
              32'h8000_002c, 0);
    // jal -8 with rd x0, no commit
    add_entry("jal_back", j_format(5'd0, 21'h1f_fff8), 32'h8000_003c, 0, 5'd0, 32'd0, 0);
    // x1 + 0x15 is odd, target drops bit 0
    add_entry("jalr_odd", i_format(OPC_JALR, 5'd11, 5'd1, 12'h015), 32'h8000_0034, 1, 5'd11,
              32'h8000_0038, 0);
    add_entry("jalr_neg", i_format(OPC_JALR, 5'd12, 5'd10, 12'hff4), 32'h8000_0040, 1, 5'd12,
              32'h8000_0044, 0);
    // sw x1, 4(x2) and beq x0, x0, +8 retire as no-ops
    add_entry("store", 32'h0011_2223, 32'h8000_0020, 0, 5'd0, 32'd0, 0);
    add_entry("branch", 32'h0000_0463, 32'h8000_0024, 0, 5'd0, 32'd0, 0);
    add_entry("ebreak", EBREAK_WORD, 32'h8000_0028, 0, 5'd0, 32'd0, 1);
    add_entry("ebreak_hold1", EBREAK_WORD, 32'h8000_0028, 0, 5'd0, 32'd0, 1);
    add_entry("ebreak_hold2", EBREAK_WORD, 32'h8000_0028, 0, 5'd0, 32'd0, 1);
    add_entry("ebreak_hold3", EBREAK_WORD, 32'h8000_0028, 0, 5'd0, 32'd0, 1);
    // execution resumes at the held pc
    add_entry("resume", i_format(OPC_IMM, 5'd13, 5'd5, 12'd1), 32'h8000_0028, 1, 5'd13,
              32'd10, 0);
    add_entry("addi_zero", i_format(OPC_IMM, 5'd14, 5'd13, 12'hff6), 32'h8000_002c, 1, 5'd14,
              32'd0, 0);
  endtask

  // watchdog, sized from the table length
  initial begin
    #((NUM_TESTS + RESET_CYCLES + 20) * CLK_PERIOD);
    $display("timeout: the test sequence did not complete in time");
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    reset     = 1'b1;
    inst      = i_format(OPC_IMM, 5'd1, 5'd0, 12'd1);
    n_entries = 0;
    errors    = 0;
    checks    = 0;
    build_table();
    assert (n_entries == NUM_TESTS)
      else begin
        errors++;
        $display("program table holds %0d rows instead of %0d", n_entries, NUM_TESTS);
      end
    // outputs under reset, ebreak included to see halt gated
    for (int i = 0; i < RESET_CYCLES - 1; i++) begin
      @(negedge clk);
      if (i == 4) begin
        inst = EBREAK_WORD;
      end
      #(CLK_PERIOD / 4);
      compare_value("reset", "pc", `RV_RESET_PC, pc);
      compare_value("reset", "wb_valid", 32'(1'b0), 32'(wb_valid));
      compare_value("reset", "halt", 32'(1'b0), 32'(halt));
    end
    @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < NUM_TESTS; i++) begin
      if (i > 0) begin
        @(negedge clk);
      end
      inst = tbl_inst[i];
      // settle, then sample well before the rising edge
      #(CLK_PERIOD / 4);
      compare_value(tbl_name[i], "pc", tbl_pc[i], pc);
      compare_value(tbl_name[i], "wb_valid", 32'(tbl_valid[i]), 32'(wb_valid));
      compare_value(tbl_name[i], "halt", 32'(tbl_halt[i]), 32'(halt));
      if (tbl_valid[i]) begin
        compare_value(tbl_name[i], "wb_rd", 32'(tbl_rd[i]), 32'(wb_rd));
        compare_value(tbl_name[i], "wb_data", tbl_data[i], wb_data);
      end
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+rtl
rtl/rv_pkg.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_writeback.sv
rtl/rv_regfile.sv
rtl/rv_core.sv
test/tb_rv_core.sv
